//--- common/mmio_pkg.sv
package mmio_pkg;

  // Command opcodes, low two bits of command byte 0
  typedef enum logic [1:0] {
    OP_GET   = 2'd0,  // APB read
    OP_SET   = 2'd1,  // APB write
    OP_READY = 2'd2,  // Completed-transfer count
    OP_QUERY = 2'd3   // Device identifier
  } mmio_op_e;

  // Response status, bits 3..2 of response byte 0
  typedef enum logic [1:0] {
    ST_OK      = 2'd0,
    ST_SLVERR  = 2'd1,  // Target flagged an error
    ST_TIMEOUT = 2'd2,  // No pready within the wait limit
    ST_FRAME   = 2'd3   // Command packet had the wrong length
  } mmio_status_e;

  // Decoded command packet
  typedef struct packed {
    mmio_op_e    op;
    logic [3:0]  tag;
    logic [23:0] addr;
    logic [15:0] value;
  } mmio_cmd_t;

  // Response word
  // Upper byte lines up with the response header byte
  typedef struct packed {
    logic [3:0]   tag;
    mmio_status_e status;
    mmio_op_e     op;     // Echo of the command opcode
    logic [15:0]  value;
  } mmio_resp_t;

  // Packet lengths in bytes
  localparam int unsigned CMD_BYTES = 6;
  localparam int unsigned RESP_BYTES = 4;

  // Byte counter of the decoder saturates one past a full packet
  localparam int unsigned CMD_CNT_W = $clog2(CMD_BYTES + 2);

  // Byte index of the encoder
  localparam int unsigned RESP_IDX_W = $clog2(RESP_BYTES);

  // Access-phase cycles allowed before the transfer is abandoned
  localparam int unsigned APB_TIMEOUT_CYCLES = 16;
  localparam int unsigned APB_TIMER_W = $clog2(APB_TIMEOUT_CYCLES);

  // Value returned by QUERY
  localparam logic [15:0] DEVICE_ID = 16'hA55A;

endpackage

//--- rtl/mmio_cmd_decoder.sv
`timescale 1ns/1ps

module mmio_cmd_decoder (
  input  logic                clock,
  input  logic                areset_n,

  // Command byte stream, Bulk-Out side
  input  logic                usb_tvalid_i,
  output logic                usb_tready_o,
  input  logic                usb_tlast_i,
  input  logic [7:0]          usb_tdata_i,

  // Decoded command, held until taken
  output logic                cmd_valid_o,
  output mmio_pkg::mmio_cmd_t cmd_o,
  output logic                frame_err_o,
  input  logic                cmd_take_i
);

  import mmio_pkg::*;

  logic [CMD_CNT_W-1:0] byte_cnt;  // Position of the next byte in the packet
  logic                 byte_move;
  logic                 len_ok;

  // Stream stalls while a command waits for the controller
  assign usb_tready_o = ~cmd_valid_o;
  assign byte_move    = usb_tvalid_i & usb_tready_o;

  // Packet is good only if tlast arrives on the sixth byte
  assign len_ok = (byte_cnt == CMD_CNT_W'(CMD_BYTES - 1));

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      byte_cnt    <= '0;
      cmd_valid_o <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      if (cmd_take_i) begin
        cmd_valid_o <= 1'b0;
      end

      if (byte_move) begin
        if (usb_tlast_i) begin
          byte_cnt    <= '0;  // Restart on every tlast
          cmd_valid_o <= 1'b1;
          frame_err_o <= ~len_ok;
        end else if (byte_cnt != '1) begin
          byte_cnt <= byte_cnt + 1'b1;  // Saturates on overlong packets
        end
      end
    end
  end

  // Field capture, little-endian
  always_ff @(posedge clock) begin
    if (byte_move) begin
      case (byte_cnt)
        CMD_CNT_W'(0): begin
          cmd_o.op  <= mmio_op_e'(usb_tdata_i[1:0]);
          cmd_o.tag <= usb_tdata_i[7:4];
        end
        CMD_CNT_W'(1): begin
          cmd_o.addr[7:0] <= usb_tdata_i;
        end
        CMD_CNT_W'(2): begin
          cmd_o.addr[15:8] <= usb_tdata_i;
        end
        CMD_CNT_W'(3): begin
          cmd_o.addr[23:16] <= usb_tdata_i;
        end
        CMD_CNT_W'(4): begin
          cmd_o.value[7:0] <= usb_tdata_i;
        end
        CMD_CNT_W'(5): begin
          cmd_o.value[15:8] <= usb_tdata_i;
        end
        default: begin
          // Surplus bytes of a long packet are dropped
        end
      endcase
    end
  end

endmodule

//--- rtl/mmio_controller.sv
`timescale 1ns/1ps

module mmio_controller (
  input  logic                   clock,
  input  logic                   areset_n,

  // From the decoder
  input  logic                   cmd_valid_i,
  input  mmio_pkg::mmio_cmd_t    cmd_i,
  input  logic                   frame_err_i,
  output logic                   cmd_take_o,

  // APB requester
  output logic                   apb_start_o,
  output logic                   apb_write_o,
  input  logic                   apb_done_i,
  input  mmio_pkg::mmio_status_e apb_status_i,
  input  logic [15:0]            apb_rdata_i,

  // Response encoder
  output logic                   resp_start_o,
  output mmio_pkg::mmio_resp_t   resp_o,
  input  logic                   resp_done_i
);

  import mmio_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCESS,   // APB transfer in flight
    S_RESPOND   // Waiting for the last response byte
  } state_e;

  state_e      state;
  mmio_op_e    op_q;
  logic [15:0] wval_q;    // Written value, echoed by SET
  logic [15:0] done_cnt;  // Completed OK transfers
  logic        is_apb;

  assign cmd_take_o  = (state == S_IDLE) & cmd_valid_i;
  assign is_apb      = ~frame_err_i & ((cmd_i.op == OP_GET) | (cmd_i.op == OP_SET));
  assign apb_write_o = (op_q == OP_SET);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state        <= S_IDLE;
      apb_start_o  <= 1'b0;
      resp_start_o <= 1'b0;
      done_cnt     <= '0;
    end else begin
      apb_start_o  <= 1'b0;
      resp_start_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (cmd_take_o) begin
            apb_start_o  <= is_apb;
            resp_start_o <= ~is_apb;  // READY, QUERY and bad frames answer at once
            state        <= is_apb ? S_ACCESS : S_RESPOND;
          end
        end
        S_ACCESS: begin
          if (apb_done_i) begin
            resp_start_o <= 1'b1;
            state        <= S_RESPOND;
          end
        end
        S_RESPOND: begin
          if (resp_done_i) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase

      if (apb_done_i && (apb_status_i == ST_OK)) begin
        done_cnt <= done_cnt + 16'd1;
      end
    end
  end

  // Command latch and response assembly
  always_ff @(posedge clock) begin
    if (cmd_take_o) begin
      op_q          <= cmd_i.op;
      wval_q        <= cmd_i.value;
      resp_o.tag    <= cmd_i.tag;
      resp_o.op     <= cmd_i.op;
      resp_o.status <= frame_err_i ? ST_FRAME : ST_OK;
      if (frame_err_i) begin
        resp_o.value <= '0;
      end else if (cmd_i.op == OP_READY) begin
        resp_o.value <= done_cnt;
      end else if (cmd_i.op == OP_QUERY) begin
        resp_o.value <= DEVICE_ID;
      end else begin
        resp_o.value <= '0;  // Filled in when the transfer ends
      end
    end else if ((state == S_ACCESS) && apb_done_i) begin
      resp_o.status <= apb_status_i;
      if (apb_status_i != ST_OK) begin
        resp_o.value <= '0;
      end else begin
        resp_o.value <= (op_q == OP_SET) ? wval_q : apb_rdata_i;
      end
    end
  end

endmodule

//--- apb_requester/mmio_apb_requester.sv
`timescale 1ns/1ps

module mmio_apb_requester (
  input  logic                   clock,
  input  logic                   areset_n,

  // Transfer request from the controller
  input  logic                   apb_start_i,
  input  logic                   apb_write_i,
  input  logic [23:0]            addr_i,
  input  logic [15:0]            wdata_i,
  output logic                   apb_done_o,
  output mmio_pkg::mmio_status_e apb_status_o,
  output logic [15:0]            apb_rdata_o,

  // APB requester port
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [23:0]            paddr_o,
  output logic [15:0]            pwdata_o,
  input  logic                   pready_i,
  input  logic                   pslverr_i,
  input  logic [15:0]            prdata_i
);

  import mmio_pkg::*;

  typedef enum logic [1:0] {
    A_IDLE,
    A_SETUP,
    A_ACCESS
  } phase_e;

  phase_e                 phase;
  logic [APB_TIMER_W-1:0] wait_cnt;  // Access-phase cycles so far
  logic                   timeout;

  assign timeout = (wait_cnt == APB_TIMER_W'(APB_TIMEOUT_CYCLES - 1));

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      phase      <= A_IDLE;
      psel_o     <= 1'b0;
      penable_o  <= 1'b0;
      apb_done_o <= 1'b0;
      wait_cnt   <= '0;
    end else begin
      apb_done_o <= 1'b0;
      case (phase)
        A_IDLE: begin
          if (apb_start_i) begin
            psel_o <= 1'b1;
            phase  <= A_SETUP;
          end
        end
        A_SETUP: begin
          penable_o <= 1'b1;
          wait_cnt  <= '0;
          phase     <= A_ACCESS;
        end
        A_ACCESS: begin
          if (pready_i || timeout) begin
            psel_o     <= 1'b0;
            penable_o  <= 1'b0;
            apb_done_o <= 1'b1;
            phase      <= A_IDLE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: phase <= A_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((phase == A_IDLE) && apb_start_i) begin
      pwrite_o <= apb_write_i;
      paddr_o  <= addr_i;
      pwdata_o <= wdata_i;
    end

    if (phase == A_ACCESS) begin
      if (pready_i) begin
        apb_rdata_o  <= prdata_i;
        apb_status_o <= pslverr_i ? ST_SLVERR : ST_OK;
      end else if (timeout) begin
        apb_rdata_o  <= '0;
        apb_status_o <= ST_TIMEOUT;  // Target never answered
      end
    end
  end

endmodule

//--- rtl/mmio_resp_encoder.sv
`timescale 1ns/1ps

module mmio_resp_encoder (
  input  logic                 clock,
  input  logic                 areset_n,

  // Response from the controller
  input  logic                 resp_start_i,
  input  mmio_pkg::mmio_resp_t resp_i,
  output logic                 resp_done_o,

  // Response byte stream, Bulk-In side
  output logic                 usb_tvalid_o,
  input  logic                 usb_tready_i,
  output logic                 usb_tlast_o,
  output logic [7:0]           usb_tdata_o
);

  import mmio_pkg::*;

  mmio_resp_t            resp_q;
  logic [RESP_IDX_W-1:0] byte_idx;
  logic [7:0]            hdr_byte;
  logic [7:0]            csum_byte;
  logic                  byte_move;
  logic                  last_byte;

  // Header byte is tag, status, opcode from the top down
  assign hdr_byte  = {resp_q.tag, resp_q.status, resp_q.op};
  assign csum_byte = hdr_byte ^ resp_q.value[7:0] ^ resp_q.value[15:8];

  assign last_byte   = (byte_idx == RESP_IDX_W'(RESP_BYTES - 1));
  assign byte_move   = usb_tvalid_o & usb_tready_i;
  assign usb_tlast_o = last_byte;
  assign resp_done_o = byte_move & last_byte;

  always_comb begin
    case (byte_idx)
      RESP_IDX_W'(0): usb_tdata_o = hdr_byte;
      RESP_IDX_W'(1): usb_tdata_o = resp_q.value[7:0];  // Little-endian
      RESP_IDX_W'(2): usb_tdata_o = resp_q.value[15:8];
      default:        usb_tdata_o = csum_byte;
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      usb_tvalid_o <= 1'b0;
      byte_idx     <= '0;
    end else begin
      if (resp_start_i) begin
        usb_tvalid_o <= 1'b1;
        byte_idx     <= '0;
      end else if (byte_move) begin
        // Index wraps back to the header after the checksum
        byte_idx <= byte_idx + 1'b1;
        if (last_byte) begin
          usb_tvalid_o <= 1'b0;
        end
      end
    end
  end

  // Response stays put until every byte has moved
  always_ff @(posedge clock) begin
    if (resp_start_i) begin
      resp_q <= resp_i;
    end
  end

endmodule

//--- rtl/usb_mmio_top.sv
`timescale 1ns/1ps

module usb_mmio_top (
  input  logic        clock,
  input  logic        areset_n,

  // Command stream in, Bulk-Out
  input  logic        usb_tvalid_i,
  output logic        usb_tready_o,
  input  logic        usb_tlast_i,
  input  logic [7:0]  usb_tdata_i,

  // Response stream out, Bulk-In
  output logic        usb_tvalid_o,
  input  logic        usb_tready_i,
  output logic        usb_tlast_o,
  output logic [7:0]  usb_tdata_o,

  // APB requester
  output logic        psel_o,
  output logic        penable_o,
  output logic        pwrite_o,
  output logic [23:0] paddr_o,
  output logic [15:0] pwdata_o,
  input  logic        pready_i,
  input  logic        pslverr_i,
  input  logic [15:0] prdata_i
);

  import mmio_pkg::*;

  mmio_cmd_t    cmd;
  logic         cmd_valid;
  logic         cmd_take;
  logic         frame_err;
  logic         apb_start;
  logic         apb_write;
  logic         apb_done;
  mmio_status_e apb_status;
  logic [15:0]  apb_rdata;
  mmio_resp_t   resp;
  logic         resp_start;
  logic         resp_done;

  mmio_cmd_decoder u_cmd_decoder (
    .clock        (clock),
    .areset_n     (areset_n),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tready_o (usb_tready_o),
    .usb_tlast_i  (usb_tlast_i),
    .usb_tdata_i  (usb_tdata_i),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd),
    .frame_err_o  (frame_err),
    .cmd_take_i   (cmd_take)
  );

  mmio_controller u_controller (
    .clock        (clock),
    .areset_n     (areset_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .frame_err_i  (frame_err),
    .cmd_take_o   (cmd_take),
    .apb_start_o  (apb_start),
    .apb_write_o  (apb_write),
    .apb_done_i   (apb_done),
    .apb_status_i (apb_status),
    .apb_rdata_i  (apb_rdata),
    .resp_start_o (resp_start),
    .resp_o       (resp),
    .resp_done_i  (resp_done)
  );

  // Address and write data come straight from the decoder, latched on apb_start
  mmio_apb_requester u_apb_requester (
    .clock        (clock),
    .areset_n     (areset_n),
    .apb_start_i  (apb_start),
    .apb_write_i  (apb_write),
    .addr_i       (cmd.addr),
    .wdata_i      (cmd.value),
    .apb_done_o   (apb_done),
    .apb_status_o (apb_status),
    .apb_rdata_o  (apb_rdata),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .pwrite_o     (pwrite_o),
    .paddr_o      (paddr_o),
    .pwdata_o     (pwdata_o),
    .pready_i     (pready_i),
    .pslverr_i    (pslverr_i),
    .prdata_i     (prdata_i)
  );

  mmio_resp_encoder u_resp_encoder (
    .clock        (clock),
    .areset_n     (areset_n),
    .resp_start_i (resp_start),
    .resp_i       (resp),
    .resp_done_o  (resp_done),
    .usb_tvalid_o (usb_tvalid_o),
    .usb_tready_i (usb_tready_i),
    .usb_tlast_o  (usb_tlast_o),
    .usb_tdata_o  (usb_tdata_o)
  );

endmodule

//--- verification/tb_apb_target.sv
`timescale 1ns/1ps

module tb_apb_target #(
  parameter logic [31:0] SEED = 32'h195f
) (
  input  logic        clock,
  input  logic        areset_n,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [23:0] paddr_i,
  input  logic [15:0] pwdata_i,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic [15:0] prdata_o
);

  logic [15:0] mem [256];
  logic [31:0] lfsr;
  logic [31:0] lfsr_1;
  logic [31:0] lfsr_2;
  logic [1:0]  wait_left;  // Wait states still to insert
  logic        mute;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Same fill as the reference model
  initial begin
    int i;
    for (i = 0; i < 256; i++) begin
      mem[i] = {8'(i) ^ 8'hc3, 8'(i)};
    end
  end

  assign mute      = paddr_i[22];  // Never answers, forces a timeout
  assign pready_o  = psel_i & penable_i & (wait_left == 2'd0) & ~mute;
  assign pslverr_o = pready_o & paddr_i[23];
  assign prdata_o  = mem[paddr_i[7:0]];

  always_comb begin
    lfsr_1 = lfsr_next(lfsr);
    lfsr_2 = lfsr_next(lfsr_1);
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      lfsr      <= SEED;
      wait_left <= 2'd0;
    end else if (psel_i && !penable_i) begin
      wait_left <= {lfsr_1[0], lfsr_2[0]};  // Two bits per transfer
      lfsr      <= lfsr_2;
    end else if (psel_i && penable_i && (wait_left != 2'd0)) begin
      wait_left <= wait_left - 2'd1;
    end
  end

  always @(posedge clock) begin
    if (pready_o && pwrite_i && !pslverr_o) begin
      mem[paddr_i[7:0]] <= pwdata_i;
    end
  end

endmodule

//--- verification/tb_usb_mmio.sv
`timescale 1ns/1ps

module tb_usb_mmio;

  localparam logic [1:0] OP_GET   = 2'd0;
  localparam logic [1:0] OP_SET   = 2'd1;
  localparam logic [1:0] OP_READY = 2'd2;
  localparam logic [1:0] OP_QUERY = 2'd3;
  localparam logic [1:0] ST_OK      = 2'd0;
  localparam logic [1:0] ST_SLVERR  = 2'd1;
  localparam logic [1:0] ST_TIMEOUT = 2'd2;
  localparam logic [1:0] ST_FRAME   = 2'd3;
  localparam logic [15:0] EXP_DEVICE_ID = 16'hA55A;
  localparam int unsigned WAIT_LIMIT = 200;  // Cycles per wait loop

  logic        clock;
  logic        areset_n;
  logic        usb_tvalid_i;
  logic        usb_tready_o;
  logic        usb_tlast_i;
  logic [7:0]  usb_tdata_i;
  logic        usb_tvalid_o;
  logic        usb_tready_i;
  logic        usb_tlast_o;
  logic [7:0]  usb_tdata_o;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [23:0] paddr;
  logic [15:0] pwdata;
  logic        pready;
  logic        pslverr;
  logic [15:0] prdata;

  logic [31:0] lfsr_state;
  logic [15:0] model_mem [256];
  logic [15:0] model_cnt;      // OK APB transfers so far
  int unsigned psel_count = 0;

  usb_mmio_top u_usb_mmio_top (
    .clock        (clock),
    .areset_n     (areset_n),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tready_o (usb_tready_o),
    .usb_tlast_i  (usb_tlast_i),
    .usb_tdata_i  (usb_tdata_i),
    .usb_tvalid_o (usb_tvalid_o),
    .usb_tready_i (usb_tready_i),
    .usb_tlast_o  (usb_tlast_o),
    .usb_tdata_o  (usb_tdata_o),
    .psel_o       (psel),
    .penable_o    (penable),
    .pwrite_o     (pwrite),
    .paddr_o      (paddr),
    .pwdata_o     (pwdata),
    .pready_i     (pready),
    .pslverr_i    (pslverr),
    .prdata_i     (prdata)
  );

  tb_apb_target u_apb_target (
    .clock     (clock),
    .areset_n  (areset_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .prdata_o  (prdata)
  );

  always #5 clock = ~clock;

  // Setup phase lasts one cycle, so this counts transfers
  always @(negedge clock) begin
    if (psel && !penable) begin
      psel_count <= psel_count + 1;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] r;
    int unsigned i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Run stopped at first error");
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic push_byte(input logic [7:0] data, input logic last);
    int unsigned waited;
    waited = 0;
    usb_tvalid_i = 1'b1;
    usb_tdata_i  = data;
    usb_tlast_i  = last;
    @(negedge clock);
    while (!usb_tready_o) begin
      waited++;
      assert (waited < WAIT_LIMIT)
        else fail_now("Command byte was never accepted, usb_tready_o stuck low");
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
  endtask

  task automatic pull_byte(output logic [7:0] data, output logic last);
    int unsigned waited;
    logic moved;
    waited = 0;
    do begin
      usb_tready_i = (take_bits(2) != 0);  // Stall about one cycle in four
      @(negedge clock);
      moved = usb_tvalid_o & usb_tready_i;
      data  = usb_tdata_o;
      last  = usb_tlast_o;
      waited++;
      assert (moved || (waited < WAIT_LIMIT))
        else fail_now("Response byte never arrived on the output stream");
      @(posedge clock);
      #1;
    end while (!moved);
    usb_tready_i = 1'b0;
  endtask

  task automatic run_cmd(input string name, input logic [1:0] op, input logic [23:0] addr,
                         input logic [15:0] value, input int unsigned len);
    logic [7:0]  pkt [7];
    logic [7:0]  exp_b [4];
    logic [7:0]  got [4];
    logic [3:0]  tag;
    logic [1:0]  st;
    logic [15:0] rval;
    logic        last;
    int unsigned psel_before;
    int unsigned exp_psel;
    int unsigned gap;
    int unsigned i;
    tag    = 4'(take_bits(4));
    pkt[0] = {tag, 2'(take_bits(2)), op};  // Bits 3..2 are unused
    pkt[1] = addr[7:0];
    pkt[2] = addr[15:8];
    pkt[3] = addr[23:16];
    pkt[4] = value[7:0];
    pkt[5] = value[15:8];
    pkt[6] = 8'(take_bits(8));

    // Reference model
    st = ST_OK;
    rval = 16'd0;
    exp_psel = 0;
    if (len != 6) begin
      st = ST_FRAME;
    end else if ((op == OP_GET) || (op == OP_SET)) begin
      exp_psel = 1;
      if (addr[22]) begin
        st = ST_TIMEOUT;
      end else if (addr[23]) begin
        st = ST_SLVERR;
      end else begin
        if (op == OP_SET) begin
          model_mem[addr[7:0]] = value;
        end
        rval = model_mem[addr[7:0]];
        model_cnt = model_cnt + 16'd1;
      end
    end else if (op == OP_READY) begin
      rval = model_cnt;
    end else begin
      rval = EXP_DEVICE_ID;
    end
    exp_b[0] = {tag, st, op};
    exp_b[1] = rval[7:0];
    exp_b[2] = rval[15:8];
    exp_b[3] = exp_b[0] ^ exp_b[1] ^ exp_b[2];

    psel_before = psel_count;
    for (i = 0; i < len; i++) begin
      gap = take_bits(2);
      repeat (gap) begin
        @(posedge clock);
        #1;
      end
      push_byte(pkt[i], i == len - 1);
    end

    for (i = 0; i < 4; i++) begin
      pull_byte(got[i], last);
      assert (got[i] == exp_b[i])
        else fail_now($sformatf("MISMATCH %s byte %0d expected %02h actual %02h",
                                name, i, exp_b[i], got[i]));
      assert (last == (i == 3))
        else fail_now($sformatf("MISMATCH %s tlast on byte %0d expected %0b actual %0b",
                                name, i, i == 3, last));
    end
    assert (!usb_tvalid_o)
      else fail_now($sformatf("Response of %s has more than four bytes", name));
    assert ((psel_count - psel_before) == exp_psel)
      else fail_now($sformatf("MISMATCH %s APB transfers expected %0d actual %0d",
                              name, exp_psel, psel_count - psel_before));
  endtask

  initial begin
    int unsigned n;
    int unsigned sel;
    int unsigned len;
    logic [1:0]  op;
    logic [1:0]  err_sel;
    logic [23:0] addr;
    logic [15:0] value;
    clock        = 1'b0;
    areset_n     = 1'b0;
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
    usb_tdata_i  = 8'd0;
    usb_tready_i = 1'b0;
    lfsr_state   = 32'h195f;
    model_cnt    = 16'd0;
    for (n = 0; n < 256; n++) begin
      model_mem[n] = {8'(n) ^ 8'hc3, 8'(n)};
    end

    @(negedge clock);
    assert (!usb_tvalid_o && !psel && !penable && usb_tready_o)
      else fail_now("Outputs are not at their reset values during reset");
    repeat (5) @(posedge clock);
    #1;
    areset_n = 1'b1;
    @(posedge clock);
    #1;

    // Write then read back
    for (n = 0; n < 8; n++) begin
      addr  = 24'(take_bits(22));
      value = 16'(take_bits(16));
      run_cmd("set_then_get_write", OP_SET, addr, value, 6);
      run_cmd("set_then_get_read", OP_GET, addr, 16'(take_bits(16)), 6);
      run_cmd("get_fill", OP_GET, 24'(take_bits(22)), 16'd0, 6);
    end
    run_cmd("query", OP_QUERY, 24'd0, 16'd0, 6);
    run_cmd("ready", OP_READY, 24'd0, 16'd0, 6);

    run_cmd("frame_short", OP_SET, addr, ~value, 5);
    run_cmd("frame_long", OP_GET, addr, value, 7);

    // Error paths leave memory and counter alone
    run_cmd("slverr_set", OP_SET, {2'b10, addr[21:0]}, ~value, 6);
    run_cmd("slverr_get", OP_GET, {2'b10, addr[21:0]}, 16'd0, 6);
    run_cmd("timeout_get", OP_GET, {2'b01, addr[21:0]}, 16'd0, 6);
    run_cmd("timeout_set", OP_SET, {2'b11, addr[21:0]}, ~value, 6);
    run_cmd("ready_after_errors", OP_READY, 24'd0, 16'd0, 6);
    run_cmd("get_after_errors", OP_GET, addr, 16'd0, 6);

    // Random mix over a small window of words
    for (n = 0; n < 80; n++) begin
      op      = 2'(take_bits(2));
      err_sel = 2'(take_bits(2));
      sel     = take_bits(2);
      addr    = {(sel == 0) ? err_sel : 2'b00, 14'(take_bits(14)), 8'(take_bits(4))};
      value   = 16'(take_bits(16));
      sel     = take_bits(3);
      len     = (sel == 0) ? 5 : ((sel == 1) ? 7 : 6);
      run_cmd("random_mix", op, addr, value, len);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- vlog.f
common/mmio_pkg.sv
rtl/mmio_cmd_decoder.sv
rtl/mmio_controller.sv
apb_requester/mmio_apb_requester.sv
rtl/mmio_resp_encoder.sv
rtl/usb_mmio_top.sv
verification/tb_apb_target.sv
verification/tb_usb_mmio.sv
